/* flist.f */
source/upscaler_pkg.sv
source/scale_ratio_divider.sv
source/input_line_capture.sv
source/output_scaler.sv
source/line_buffer_arbiter.sv
source/line_buffer_ram.sv
source/upscaler_top.sv
verif/tb_upscaler.sv

/* run_sim.sh */
#!/usr/bin/env bash
rm -f sim.log \
	&& verilator --binary --timing -f flist.f --top-module tb_upscaler -o tb_upscaler \
	&& ./obj_dir/tb_upscaler > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log \
	&& { echo "simulation reported errors"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* source/input_line_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module input_line_capture
	import upscaler_pkg::*;
#(
	parameter int LINE_WIDTH = 16,
	parameter int LINE_COUNT = 16
) (
	input  wire         i_ClkB,
	input  wire         i_rst,
	input  wire         i_in_pix_en,
	input  wire         i_in_hblank,
	input  wire         i_in_vblank,
	input  wire rgb_pixel_t i_in_pix,
	input  wire wb_rsp_t    i_wb_rsp,
	output wb_req_t     o_wb_req,
	output pix_index_t  o_in_width,
	output line_index_t o_in_height,
	output line_index_t o_sof_slot,
	output logic        o_frame_valid
);

	typedef enum logic {WR_IDLE, WR_BUSY} wr_state_t;

	wr_state_t   wr_state;
	logic        hblank_q;
	logic        vblank_q;
	logic        active;
	logic        hblank_rise;
	logic        line_end;
	logic        frame_end;
	pix_index_t  pix_cnt;
	line_index_t line_cnt;
	line_index_t line_total;
	line_index_t wr_slot;
	line_index_t wr_slot_next;
	line_index_t frame_slot;
	buf_addr_t   wr_adr;
	rgb_pixel_t  wr_dat;

	assign active = i_in_pix_en && !i_in_hblank && !i_in_vblank;

	// rising blank edges close a line or a frame
	assign hblank_rise = i_in_pix_en && i_in_hblank && !hblank_q;
	assign line_end    = hblank_rise && (pix_cnt != '0);
	assign frame_end   = i_in_pix_en && i_in_vblank && !vblank_q;

	// line count including a line that ends in this same cycle
	assign line_total = line_cnt + line_index_t'(line_end);

	always_comb begin
		wr_slot_next = wr_slot;
		if (line_end) begin
			wr_slot_next = (wr_slot == line_index_t'(LINE_COUNT - 1)) ? '0 : wr_slot + 1'b1;
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hblank_q      <= 1'b0;
			vblank_q      <= 1'b0;
			pix_cnt       <= '0;
			line_cnt      <= '0;
			wr_slot       <= '0;
			frame_slot    <= '0;
			o_in_width    <= '0;
			o_in_height   <= '0;
			o_sof_slot    <= '0;
			o_frame_valid <= 1'b0;
			wr_state      <= WR_IDLE;
		end else begin
			if (i_in_pix_en) begin
				hblank_q <= i_in_hblank;
				vblank_q <= i_in_vblank;
			end

			if (hblank_rise) begin
				pix_cnt <= '0;
			end else if (active) begin
				pix_cnt <= pix_cnt + 1'b1;
			end

			// width of the line just finished
			if (line_end) begin
				o_in_width <= pix_cnt;
			end

			wr_slot <= wr_slot_next;

			if (frame_end) begin
				line_cnt   <= '0;
				frame_slot <= wr_slot_next;
				// publish only frames that held active lines
				if (line_total != '0) begin
					o_in_height   <= line_total;
					o_sof_slot    <= frame_slot;
					o_frame_valid <= 1'b1;
				end
			end else begin
				line_cnt <= line_total;
			end

			case (wr_state)
				WR_IDLE: if (active) wr_state <= WR_BUSY;
				WR_BUSY: if (i_wb_rsp.ack) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// pixels arriving during a pending write are dropped
	always_ff @(posedge i_ClkB) begin
		if (active && (wr_state == WR_IDLE)) begin
			wr_adr <= buf_addr_t'(wr_slot * LINE_WIDTH + pix_cnt);
			wr_dat <= i_in_pix;
		end
	end

	assign o_wb_req = '{
		cyc: (wr_state == WR_BUSY),
		stb: (wr_state == WR_BUSY),
		we:  1'b1,
		adr: wr_adr,
		dat: wr_dat
	};

endmodule

`default_nettype wire

/* source/line_buffer_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_arbiter
	import upscaler_pkg::*;
(
	input  wire          i_ClkB,
	input  wire          i_rst,
	input  wire wb_req_t i_cap_req,
	input  wire wb_req_t i_scl_req,
	input  wire wb_rsp_t i_mem_rsp,
	output wb_rsp_t      o_cap_rsp,
	output wb_rsp_t      o_scl_rsp,
	output wb_req_t      o_mem_req
);

	typedef enum logic [1:0] {GNT_IDLE, GNT_CAP, GNT_SCL} grant_t;

	grant_t grant;
	logic   last_scl;
	logic   hold_cap;
	logic   hold_scl;
	logic   sel_cap;
	logic   sel_scl;

	// a grant lasts while its master keeps cyc up
	assign hold_cap = (grant == GNT_CAP) && i_cap_req.cyc;
	assign hold_scl = (grant == GNT_SCL) && i_scl_req.cyc;

	// free bus is granted in the cycle cyc rises
	// on a tie the master not served last goes first
	assign sel_cap = hold_cap ||
		(!hold_scl && i_cap_req.cyc && (!i_scl_req.cyc || last_scl));
	assign sel_scl = !sel_cap && i_scl_req.cyc;

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			grant    <= GNT_IDLE;
			last_scl <= 1'b0;
		end else begin
			if (sel_cap) begin
				grant <= GNT_CAP;
			end else if (sel_scl) begin
				grant <= GNT_SCL;
			end else begin
				grant <= GNT_IDLE;
			end
			if (sel_cap || sel_scl) begin
				last_scl <= sel_scl;
			end
		end
	end

	always_comb begin
		o_mem_req = '0;
		if (sel_cap) begin
			o_mem_req = i_cap_req;
		end else if (sel_scl) begin
			o_mem_req = i_scl_req;
		end
	end

	// ack only to the granted master
	assign o_cap_rsp = '{ack: i_mem_rsp.ack && sel_cap, dat: i_mem_rsp.dat};
	assign o_scl_rsp = '{ack: i_mem_rsp.ack && sel_scl, dat: i_mem_rsp.dat};

endmodule

`default_nettype wire

/* source/line_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_ram
	import upscaler_pkg::*;
#(
	parameter int LINE_WIDTH = 16,
	parameter int LINE_COUNT = 16
) (
	input  wire          i_ClkB,
	input  wire          i_rst,
	input  wire wb_req_t i_wb_req,
	output wb_rsp_t      o_wb_rsp
);

	localparam int SLOT_W = $clog2(LINE_COUNT);
	localparam int PIX_W  = $clog2(LINE_WIDTH);

	rgb_pixel_t        mem [LINE_COUNT][LINE_WIDTH];
	logic              ack;
	logic              access;
	logic [SLOT_W-1:0] slot;
	logic [PIX_W-1:0]  pix;
	rgb_pixel_t        rd_dat;

	// a strobe still high in the ack cycle is not served again
	assign access = i_wb_req.cyc && i_wb_req.stb && !ack;

	assign slot = SLOT_W'(i_wb_req.adr / LINE_WIDTH);
	assign pix  = PIX_W'(i_wb_req.adr % LINE_WIDTH);

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (access && i_wb_req.we) begin
			mem[slot][pix] <= i_wb_req.dat;
		end else if (access) begin
			rd_dat <= mem[slot][pix];
		end
	end

	assign o_wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

`default_nettype wire

/* source/output_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module output_scaler
	import upscaler_pkg::*;
#(
	parameter int LINE_WIDTH = 16,
	parameter int LINE_COUNT = 16
) (
	input  wire              i_ClkB,
	input  wire              i_rst,
	input  wire              i_out_pix_en,
	input  wire              i_out_hblank,
	input  wire              i_out_vblank,
	input  wire pix_index_t  i_in_width,
	input  wire line_index_t i_in_height,
	input  wire line_index_t i_sof_slot,
	input  wire              i_frame_valid,
	input  wire wb_rsp_t     i_wb_rsp,
	output wb_req_t          o_wb_req,
	output rgb_pixel_t       o_pix,
	output logic             o_pix_valid,
	output logic             o_locked
);

	// five integer bits above the fraction
	localparam int ACC_W = RATIO_FRAC + 5;

	typedef enum logic {RD_IDLE, RD_BUSY} rd_state_t;

	rd_state_t   rd_state;
	logic        hblank_q;
	logic        vblank_q;
	logic        active;
	logic        hblank_rise;
	logic        line_end;
	logic        frame_end;
	logic        frame_start;
	logic        lock_next;
	logic        rd_go;
	pix_index_t  pix_cnt;
	line_index_t line_cnt;
	line_index_t line_total;
	ratio_t      h_ratio;
	ratio_t      v_ratio;
	ratio_t      h_step;
	ratio_t      v_step;
	logic        h_done;
	logic        v_done;
	logic [ACC_W-1:0] h_acc;
	logic [ACC_W-1:0] h_pos;
	logic [ACC_W-1:0] v_acc;
	logic [ACC_W-1:0] v_base;
	logic [ACC_W-1:0] v_pos;
	pix_index_t  pix_sel;
	pix_index_t  src_pix;
	line_index_t line_sel;
	line_index_t src_line;
	line_index_t sof_q;
	line_index_t slot_base;
	line_index_t rd_slot;
	buf_addr_t   rd_adr;
	buf_addr_t   rd_adr_q;

	assign active      = i_out_pix_en && !i_out_hblank && !i_out_vblank;
	assign hblank_rise = i_out_pix_en && i_out_hblank && !hblank_q;
	assign line_end    = hblank_rise && (pix_cnt != '0);
	assign frame_end   = i_out_pix_en && i_out_vblank && !vblank_q;
	assign frame_start = i_out_pix_en && !i_out_vblank && vblank_q;
	assign line_total  = line_cnt + line_index_t'(line_end);

	// new steps are worked out in blanking, measured size as denominator
	scale_ratio_divider u_hratio (
		.i_ClkB  (i_ClkB),
		.i_rst   (i_rst),
		.i_start (line_end),
		.i_num   (i_in_width),
		.i_den   (pix_cnt),
		.o_ratio (h_ratio),
		.o_done  (h_done)
	);

	scale_ratio_divider u_vratio (
		.i_ClkB  (i_ClkB),
		.i_rst   (i_rst),
		.i_start (frame_end),
		.i_num   (i_in_height),
		.i_den   (line_total),
		.o_ratio (v_ratio),
		.o_done  (v_done)
	);

	// accumulators add before use
	assign h_pos   = h_acc + h_step;
	assign v_base  = frame_start ? '0 : v_acc;
	assign v_pos   = (pix_cnt == '0) ? v_base + v_step : v_base;
	assign pix_sel = h_pos[ACC_W-1:RATIO_FRAC];
	assign line_sel = v_pos[ACC_W-1:RATIO_FRAC];

	// clamp to the last stored pixel and line
	assign src_pix  = (pix_sel >= i_in_width) ? i_in_width - 1'b1 : pix_sel;
	assign src_line = (line_sel >= i_in_height) ? i_in_height - 1'b1 : line_sel;

	assign slot_base = frame_start ? i_sof_slot : sof_q;
	assign rd_slot   = line_index_t'((slot_base + src_line) % LINE_COUNT);
	assign rd_adr    = buf_addr_t'(rd_slot * LINE_WIDTH + src_pix);

	// lock needs a stored frame and both steps in place
	assign lock_next = o_locked ||
		(frame_start && i_frame_valid && (h_step != '0) && (v_step != '0));
	assign rd_go = active && lock_next && (rd_state == RD_IDLE);

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hblank_q    <= 1'b0;
			vblank_q    <= 1'b0;
			pix_cnt     <= '0;
			line_cnt    <= '0;
			h_acc       <= '0;
			v_acc       <= '0;
			sof_q       <= '0;
			h_step      <= '0;
			v_step      <= '0;
			o_locked    <= 1'b0;
			o_pix_valid <= 1'b0;
			rd_state    <= RD_IDLE;
		end else begin
			if (i_out_pix_en) begin
				hblank_q <= i_out_hblank;
				vblank_q <= i_out_vblank;
			end

			if (hblank_rise) begin
				pix_cnt <= '0;
				h_acc   <= '0;
			end else if (active) begin
				pix_cnt <= pix_cnt + 1'b1;
				h_acc   <= h_pos;
			end

			if (frame_end) begin
				line_cnt <= '0;
			end else begin
				line_cnt <= line_total;
			end

			if (active) begin
				v_acc <= v_pos;
			end else if (frame_start) begin
				v_acc <= '0;
			end

			if (frame_start) begin
				sof_q <= i_sof_slot;
			end

			if (h_done) begin
				h_step <= h_ratio;
			end
			if (v_done) begin
				v_step <= v_ratio;
			end

			o_locked    <= lock_next;
			o_pix_valid <= (rd_state == RD_BUSY) && i_wb_rsp.ack;

			case (rd_state)
				RD_IDLE: if (rd_go) rd_state <= RD_BUSY;
				RD_BUSY: if (i_wb_rsp.ack) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (rd_go) begin
			rd_adr_q <= rd_adr;
		end
		// read data comes with ack
		if ((rd_state == RD_BUSY) && i_wb_rsp.ack) begin
			o_pix <= i_wb_rsp.dat;
		end
	end

	assign o_wb_req = '{
		cyc: (rd_state == RD_BUSY),
		stb: (rd_state == RD_BUSY),
		we:  1'b0,
		adr: rd_adr_q,
		dat: '0
	};

endmodule

`default_nettype wire

/* source/scale_ratio_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module scale_ratio_divider
	import upscaler_pkg::*;
(
	input  wire             i_ClkB,
	input  wire             i_rst,
	input  wire             i_start,
	input  wire pix_index_t i_num,
	input  wire pix_index_t i_den,
	output ratio_t          o_ratio,
	output logic            o_done
);

	// one quotient bit per cycle
	localparam int STEPS = RATIO_FRAC + 1;
	localparam int CNT_W = $clog2(STEPS + 1);

	logic             busy;
	logic [CNT_W-1:0] step_cnt;
	logic [4:0]       rem;
	logic [5:0]       rem_shift;
	logic [5:0]       rem_diff;
	logic             fits;
	logic [RATIO_FRAC:0] dvd;
	ratio_t           quo;
	pix_index_t       den_q;

	// bring down the next dividend bit and trial subtract
	assign rem_shift = {rem, dvd[RATIO_FRAC]};
	assign rem_diff  = rem_shift - {1'b0, den_q};
	assign fits      = (rem_shift >= {1'b0, den_q});

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy     <= 1'b1;
				step_cnt <= CNT_W'(STEPS);
			end else if (busy) begin
				step_cnt <= step_cnt - 1'b1;
				if (step_cnt == CNT_W'(1)) begin
					busy   <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// upper dividend bits preload the remainder, num < 2*den keeps it in range
	always_ff @(posedge i_ClkB) begin
		if (i_start) begin
			rem   <= i_num >> 1;
			dvd   <= {i_num[0], {RATIO_FRAC{1'b0}}};
			den_q <= i_den;
			quo   <= '0;
		end else if (busy) begin
			rem <= fits ? rem_diff[4:0] : rem_shift[4:0];
			dvd <= dvd << 1;
			quo <= {quo[RATIO_FRAC-1:0], fits};
			if (step_cnt == CNT_W'(1)) begin
				// zero denominator gives a zero step
				o_ratio <= (den_q == '0) ? '0 : {quo[RATIO_FRAC-1:0], fits};
			end
		end
	end

endmodule

`default_nettype wire

/* source/upscaler_pkg.sv */
`default_nettype none

package upscaler_pkg;

	// fraction bits of the scale steps and position accumulators
	localparam int RATIO_FRAC = 12;

	typedef logic [7:0] component_t;

	typedef struct packed {
		component_t red;
		component_t green;
		component_t blue;
	} rgb_pixel_t;

	typedef logic [4:0] pix_index_t;
	typedef logic [4:0] line_index_t;

	// ring slot times line width, plus pixel index
	typedef logic [7:0] buf_addr_t;

	// one integer bit, enough for upscale and 1:1
	typedef logic [RATIO_FRAC:0] ratio_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		buf_addr_t  adr;
		rgb_pixel_t dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		rgb_pixel_t dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* source/upscaler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module upscaler_top
	import upscaler_pkg::*;
#(
	parameter int LINE_WIDTH = 16,
	parameter int LINE_COUNT = 16
) (
	input  wire             i_ClkB,
	input  wire             i_rst,
	input  wire             i_in_pix_en,
	input  wire             i_in_hblank,
	input  wire             i_in_vblank,
	input  wire rgb_pixel_t i_in_pix,
	input  wire             i_out_pix_en,
	input  wire             i_out_hblank,
	input  wire             i_out_vblank,
	output rgb_pixel_t      o_pix,
	output logic            o_pix_valid,
	output logic            o_locked
);

	wb_req_t     cap_req;
	wb_rsp_t     cap_rsp;
	wb_req_t     scl_req;
	wb_rsp_t     scl_rsp;
	wb_req_t     mem_req;
	wb_rsp_t     mem_rsp;
	pix_index_t  in_width;
	line_index_t in_height;
	line_index_t sof_slot;
	logic        frame_valid;

	input_line_capture #(
		.LINE_WIDTH (LINE_WIDTH),
		.LINE_COUNT (LINE_COUNT)
	) u_capture (
		.i_ClkB        (i_ClkB),
		.i_rst         (i_rst),
		.i_in_pix_en   (i_in_pix_en),
		.i_in_hblank   (i_in_hblank),
		.i_in_vblank   (i_in_vblank),
		.i_in_pix      (i_in_pix),
		.i_wb_rsp      (cap_rsp),
		.o_wb_req      (cap_req),
		.o_in_width    (in_width),
		.o_in_height   (in_height),
		.o_sof_slot    (sof_slot),
		.o_frame_valid (frame_valid)
	);

	output_scaler #(
		.LINE_WIDTH (LINE_WIDTH),
		.LINE_COUNT (LINE_COUNT)
	) u_scaler (
		.i_ClkB        (i_ClkB),
		.i_rst         (i_rst),
		.i_out_pix_en  (i_out_pix_en),
		.i_out_hblank  (i_out_hblank),
		.i_out_vblank  (i_out_vblank),
		.i_in_width    (in_width),
		.i_in_height   (in_height),
		.i_sof_slot    (sof_slot),
		.i_frame_valid (frame_valid),
		.i_wb_rsp      (scl_rsp),
		.o_wb_req      (scl_req),
		.o_pix         (o_pix),
		.o_pix_valid   (o_pix_valid),
		.o_locked      (o_locked)
	);

	line_buffer_arbiter u_arbiter (
		.i_ClkB    (i_ClkB),
		.i_rst     (i_rst),
		.i_cap_req (cap_req),
		.i_scl_req (scl_req),
		.i_mem_rsp (mem_rsp),
		.o_cap_rsp (cap_rsp),
		.o_scl_rsp (scl_rsp),
		.o_mem_req (mem_req)
	);

	line_buffer_ram #(
		.LINE_WIDTH (LINE_WIDTH),
		.LINE_COUNT (LINE_COUNT)
	) u_ram (
		.i_ClkB   (i_ClkB),
		.i_rst    (i_rst),
		.i_wb_req (mem_req),
		.o_wb_rsp (mem_rsp)
	);

endmodule

`default_nettype wire

/* verif/tb_upscaler.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_upscaler
	import upscaler_pkg::*;
();

	localparam int HBLANK_PIX   = 3;
	localparam int VBLANK_LINES = 1;
	localparam int LOCK_TIMEOUT = 50000;
	localparam int PIX_TIMEOUT  = 3000;
	localparam int DATA_WORDS   = 512;

	logic       i_ClkB = 1'b0;
	logic       i_rst;
	logic       i_in_pix_en;
	logic       i_in_hblank;
	logic       i_in_vblank;
	rgb_pixel_t i_in_pix;
	logic       i_out_pix_en;
	logic       i_out_hblank;
	logic       i_out_vblank;
	rgb_pixel_t o_pix;
	logic       o_pix_valid;
	logic       o_locked;

	logic [23:0] data_mem [DATA_WORDS];
	rgb_pixel_t  image [256];
	int          in_w;
	int          in_h;
	int          out_w;
	int          out_h;
	int          spacing;
	int          err_count;
	int          test_count;
	int          failed_tests;
	logic        stop_raster;
	logic        timed_out;
	logic        in_frame_done;
	time         in_done_time;
	time         out_start_times[$];

	upscaler_top #(
		.LINE_WIDTH (16),
		.LINE_COUNT (16)
	) i_dut (
		.i_ClkB       (i_ClkB),
		.i_rst        (i_rst),
		.i_in_pix_en  (i_in_pix_en),
		.i_in_hblank  (i_in_hblank),
		.i_in_vblank  (i_in_vblank),
		.i_in_pix     (i_in_pix),
		.i_out_pix_en (i_out_pix_en),
		.i_out_hblank (i_out_hblank),
		.i_out_vblank (i_out_vblank),
		.o_pix        (o_pix),
		.o_pix_valid  (o_pix_valid),
		.o_locked     (o_locked)
	);

	always #50 i_ClkB = ~i_ClkB;

	task automatic check_pixel(input rgb_pixel_t actual, input rgb_pixel_t expected,
		input string what);
		if (actual !== expected) begin
			err_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			err_count++;
			$display("mismatch at %0t: %s got %b expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		if (actual != expected) begin
			err_count++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
		end
	endtask

	// nearest source pixel for one output position
	function automatic rgb_pixel_t expected_pixel(input int x, input int y);
		int h_ratio;
		int v_ratio;
		int src_x;
		int src_y;
		h_ratio = (in_w << RATIO_FRAC) / out_w;
		v_ratio = (in_h << RATIO_FRAC) / out_h;
		// step is added before the position is used
		src_x = (h_ratio * (x + 1)) >> RATIO_FRAC;
		src_y = (v_ratio * (y + 1)) >> RATIO_FRAC;
		if (src_x > in_w - 1) begin
			src_x = in_w - 1;
		end
		if (src_y > in_h - 1) begin
			src_y = in_h - 1;
		end
		return image[src_y * in_w + src_x];
	endfunction

	// idle cycles after the enable cycle and the cycle that drops it
	function automatic int enable_gap();
		return spacing - 2 + int'($urandom % 4);
	endfunction

	task automatic apply_reset();
		int n;
		@(posedge i_ClkB);
		i_rst        <= 1'b1;
		i_in_pix_en  <= 1'b0;
		i_in_hblank  <= 1'b0;
		i_in_vblank  <= 1'b0;
		i_in_pix     <= '0;
		i_out_pix_en <= 1'b0;
		i_out_hblank <= 1'b0;
		i_out_vblank <= 1'b0;
		for (n = 0; n < 3; n++) begin
			@(posedge i_ClkB);
			if (n == 2) begin
				i_rst <= 1'b0;
			end
			@(negedge i_ClkB);
			check_flag(o_pix_valid, 1'b0, "o_pix_valid in reset");
			check_flag(o_locked, 1'b0, "o_locked in reset");
		end
		@(posedge i_ClkB);
		@(negedge i_ClkB);
		check_flag(o_pix_valid, 1'b0, "o_pix_valid after reset");
		check_flag(o_locked, 1'b0, "o_locked after reset");
	endtask

	// frames open with vblank lines, then active lines with trailing hblank
	task automatic drive_input_raster();
		int frame;
		int x;
		int y;
		frame = 0;
		while (!stop_raster) begin
			for (y = 0; y < VBLANK_LINES + in_h; y++) begin
				for (x = 0; x < in_w + HBLANK_PIX; x++) begin
					@(posedge i_ClkB);
					i_in_pix_en <= 1'b1;
					i_in_vblank <= (y < VBLANK_LINES);
					i_in_hblank <= (x >= in_w);
					if ((y >= VBLANK_LINES) && (x < in_w)) begin
						i_in_pix <= image[(y - VBLANK_LINES) * in_w + x];
					end else begin
						i_in_pix <= '0;
					end
					// first frame is published at this vblank pixel
					if ((frame == 1) && (y == 0) && (x == 0)) begin
						in_frame_done = 1'b1;
						in_done_time  = $time;
					end
					@(posedge i_ClkB);
					i_in_pix_en <= 1'b0;
					repeat (enable_gap()) @(posedge i_ClkB);
				end
			end
			frame++;
		end
	endtask

	task automatic drive_output_raster();
		int x;
		int y;
		while (!stop_raster) begin
			for (y = 0; y < VBLANK_LINES + out_h; y++) begin
				for (x = 0; x < out_w + HBLANK_PIX; x++) begin
					@(posedge i_ClkB);
					i_out_pix_en <= 1'b1;
					i_out_vblank <= (y < VBLANK_LINES);
					i_out_hblank <= (x >= out_w);
					if ((y == VBLANK_LINES) && (x == 0)) begin
						out_start_times.push_back($time);
					end
					@(posedge i_ClkB);
					i_out_pix_en <= 1'b0;
					repeat (enable_gap()) @(posedge i_ClkB);
				end
			end
		end
	endtask

	task automatic check_output();
		int  cycles;
		int  starts;
		int  k;
		int  pulses;
		int  lock_frames;
		time lock_time;
		cycles = 0;
		@(negedge i_ClkB);
		while (!o_locked && (cycles < LOCK_TIMEOUT)) begin
			@(negedge i_ClkB);
			cycles++;
		end
		if (!o_locked) begin
			timed_out = 1'b1;
			err_count++;
			$display("o_locked never rose within %0d cycles", LOCK_TIMEOUT);
			return;
		end
		lock_time = $time;
		check_flag(in_frame_done, 1'b1, "input frame complete before lock");
		// output frame starts between input completion and lock
		starts = 0;
		foreach (out_start_times[i]) begin
			if ((out_start_times[i] > in_done_time) && (out_start_times[i] < lock_time)) begin
				starts++;
			end
		end
		check_flag((starts >= 1) && (starts <= 2), 1'b1, "lock within two output frames");
		lock_frames = out_start_times.size();
		pulses = 0;
		for (k = 0; k < out_w * out_h; k++) begin
			cycles = 0;
			do begin
				@(negedge i_ClkB);
				cycles++;
				check_flag(o_locked, 1'b1, "o_locked held");
			end while (!o_pix_valid && (cycles < PIX_TIMEOUT));
			if (!o_pix_valid) begin
				timed_out = 1'b1;
				err_count++;
				$display("no valid pixel arrived for output pixel %0d of %0d", k, out_w * out_h);
				return;
			end
			// only pulses of the locked frame count
			if (out_start_times.size() == lock_frames) begin
				pulses++;
			end
			check_pixel(o_pix, expected_pixel(k % out_w, k / out_w),
				$sformatf("pixel x %0d y %0d", k % out_w, k / out_w));
		end
		// extra pulses before the next frame begins
		cycles = 0;
		while ((out_start_times.size() == lock_frames) && (cycles < LOCK_TIMEOUT)) begin
			@(negedge i_ClkB);
			cycles++;
			if (o_pix_valid) begin
				pulses++;
			end
		end
		if (out_start_times.size() == lock_frames) begin
			timed_out = 1'b1;
			err_count++;
			$display("the next output frame never started");
			return;
		end
		check_count(pulses, out_w * out_h, "o_pix_valid pulses in one frame");
	endtask

	initial begin
		int ptr;
		int errs_before;
		int i;
		err_count    = 0;
		test_count   = 0;
		failed_tests = 0;
		stop_raster  = 1'b0;
		timed_out    = 1'b0;
		i_rst        = 1'b1;
		i_in_pix_en  = 1'b0;
		i_in_hblank  = 1'b0;
		i_in_vblank  = 1'b0;
		i_in_pix     = '0;
		i_out_pix_en = 1'b0;
		i_out_hblank = 1'b0;
		i_out_vblank = 1'b0;
		void'($urandom(32'he3ba));
		$readmemh("verif/upscaler_input.txt", data_mem);
		ptr = 0;
		while (!timed_out && (ptr + 5 <= DATA_WORDS) && (data_mem[ptr] != '0)) begin
			in_w    = int'(data_mem[ptr]);
			in_h    = int'(data_mem[ptr + 1]);
			out_w   = int'(data_mem[ptr + 2]);
			out_h   = int'(data_mem[ptr + 3]);
			spacing = int'(data_mem[ptr + 4]);
			for (i = 0; i < in_w * in_h; i++) begin
				image[i] = data_mem[ptr + 5 + i];
			end
			ptr = ptr + 5 + in_w * in_h;
			test_count++;
			errs_before   = err_count;
			stop_raster   = 1'b0;
			in_frame_done = 1'b0;
			in_done_time  = 0;
			out_start_times.delete();
			apply_reset();
			fork
				drive_input_raster();
				drive_output_raster();
				begin
					check_output();
					stop_raster = 1'b1;
				end
			join
			if (err_count == errs_before) begin
				$display("test %0d %0dx%0d to %0dx%0d spacing %0d ok", test_count,
					in_w, in_h, out_w, out_h, spacing);
			end else begin
				failed_tests++;
				$display("test %0d %0dx%0d to %0dx%0d spacing %0d failed with %0d errors",
					test_count, in_w, in_h, out_w, out_h, spacing, err_count - errs_before);
			end
		end
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
		if ((err_count == 0) && (test_count > 0)) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/upscaler_input.txt */
// each record holds in_width in_height out_width out_height spacing
// then in_width*in_height rgb pixels in hex in raster order
// a record of zeros ends the list
// 4x4 to 8x8 integer upscale
4 4 8 8 6
ff0000 00ff00 0000ff ffffff
101010 202020 303030 404040
a01020 b03040 c05060 d07080
0f1e2d 3c4b5a 69788a 9aabbc
// 3x3 to 5x7 non-integer upscale
3 3 5 7 7
123456 789abc def012
345678 9abcde f01234
56789a bcdef0 13579b
// 4x3 at 1:1
4 3 4 3 6
010203 040506 070809 0a0b0c
111213 141516 171819 1a1b1c
212223 242526 272829 2a2b2c
// 2x2 to 7x5 with wide spacing
2 2 7 5 9
c0ffee 00beef
facade 0ddba1
// 6x4 to 9x6
6 4 9 6 8
800000 008000 000080 808000 800080 008080
c00000 00c000 0000c0 c0c000 c000c0 00c0c0
400000 004000 000040 404000 400040 004040
e0e0e0 a0a0a0 606060 202020 f0f0f0 0a0a0a
// end of list
0 0 0 0 0
